// File: design/miss_handler_pkg.sv
`default_nettype none

package miss_handler_pkg;

    // Cache geometry
    localparam int unsigned N_BANKS     = 2;
    localparam int unsigned BANK_ID_W   = 1;
    localparam int unsigned NLINE_W     = 27;
    localparam int unsigned CL_OFFSET_W = 5;
    localparam int unsigned ADDR_W      = 32;
    localparam int unsigned MSHR_ID_W   = 3;
    localparam int unsigned MEM_ID_W    = BANK_ID_W + MSHR_ID_W;

    // Refill data path
    localparam int unsigned MEM_DATA_W        = 64;
    localparam int unsigned REFILL_DATA_W     = 128;
    localparam int unsigned WORD_IDX_W        = 2;
    localparam int unsigned ACCESS_WORDS      = 2;
    localparam int unsigned REFILL_LAST_WORD  = 2;
    localparam int unsigned REFILL_FIFO_DEPTH = 2;
    localparam int unsigned DATA_FIFO_DEPTH   = 4;

    // Send FSM states
    localparam logic MISS_IDLE = 1'b0;
    localparam logic MISS_SEND = 1'b1;

    // Refill FSM states
    localparam logic REFILL_IDLE  = 1'b0;
    localparam logic REFILL_WRITE = 1'b1;

    typedef struct packed {
        logic [BANK_ID_W-1:0] bank;
        logic [MSHR_ID_W-1:0] mshr_id;
    } mem_id_fields_t;

    // Memory transaction ID as a raw tag or as bank plus MSHR entry
    typedef union packed {
        logic [MEM_ID_W-1:0] raw;
        mem_id_fields_t      f;
    } mem_id_u;

endpackage

`default_nettype wire

// File: design/miss_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module miss_fifo #(
    parameter int unsigned WIDTH       = 8,
    parameter int unsigned DEPTH       = 2,
    parameter bit          FEEDTHROUGH = 1'b0
) (
    input  logic             clk_i,
    input  logic             rst_ni,
    input  logic             w_i,
    input  logic [WIDTH-1:0] wdata_i,
    output logic             wok_o,
    input  logic             r_i,
    output logic             rok_o,
    output logic [WIDTH-1:0] rdata_o
);

    logic [WIDTH-1:0]         mem_q [DEPTH];
    logic [$clog2(DEPTH)-1:0] wptr_q, rptr_q, wptr_inc, rptr_inc;
    logic                     full_q, empty, bypass, store, fetch;

    assign wptr_inc = (wptr_q == DEPTH - 1) ? '0 : wptr_q + 1'b1;
    assign rptr_inc = (rptr_q == DEPTH - 1) ? '0 : rptr_q + 1'b1;

    assign empty   = (wptr_q == rptr_q) && !full_q;
    assign bypass  = FEEDTHROUGH && empty;
    assign wok_o   = !full_q;
    assign rok_o   = !empty || (bypass && w_i);
    assign rdata_o = bypass ? wdata_i : mem_q[rptr_q];

    // A write into an empty feedthrough FIFO that is read at once never gets stored
    assign store = w_i && !full_q && !(bypass && r_i);
    assign fetch = r_i && !empty;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            wptr_q <= '0;
            rptr_q <= '0;
            full_q <= 1'b0;
        end else begin
            if (store) begin
                wptr_q <= wptr_inc;
            end
            if (fetch) begin
                rptr_q <= rptr_inc;
            end
            if (store && !fetch) begin
                full_q <= (wptr_inc == rptr_q);
            end else if (fetch && !store) begin
                full_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (store) begin
            mem_q[wptr_q] <= wdata_i;
        end
    end

endmodule

`default_nettype wire

// File: design/miss_req_path.sv
`timescale 1ns/1ps
`default_nettype none

module miss_req_path
    import miss_handler_pkg::*;
(
    input  logic                                clk_i,
    input  logic                                rst_ni,
    input  logic [N_BANKS-1:0]                  miss_req_valid_i,
    input  logic [N_BANKS-1:0][NLINE_W-1:0]     miss_req_nline_i,
    input  logic [N_BANKS-1:0][MSHR_ID_W-1:0]   miss_req_mshr_id_i,
    output logic [N_BANKS-1:0]                  miss_req_ready_o,
    input  logic                                mem_req_ready_i,
    output logic                                mem_req_valid_o,
    output logic [ADDR_W-1:0]                   mem_req_addr_o,
    output logic [MEM_ID_W-1:0]                 mem_req_id_o
);

    logic [N_BANKS-1:0]                           buf_rok, buf_r;
    logic [N_BANKS-1:0][NLINE_W+MSHR_ID_W-1:0]    buf_rdata;
    logic [BANK_ID_W-1:0]                         gnt_bank;
    logic                                         gnt_any;
    logic                                         state_q;
    logic [NLINE_W-1:0]                           nline_q;
    mem_id_u                                      id_q, id_d;

    for (genvar b = 0; b < N_BANKS; b++) begin : gen_req_buf
        miss_fifo #(
            .WIDTH       (NLINE_W + MSHR_ID_W),
            .DEPTH       (2),
            .FEEDTHROUGH (1'b1)
        ) i_req_buf (
            .clk_i   (clk_i),
            .rst_ni  (rst_ni),
            .w_i     (miss_req_valid_i[b]),
            .wdata_i ({miss_req_nline_i[b], miss_req_mshr_id_i[b]}),
            .wok_o   (miss_req_ready_o[b]),
            .r_i     (buf_r[b]),
            .rok_o   (buf_rok[b]),
            .rdata_o (buf_rdata[b])
        );

        // Pop the granted buffer only while the send FSM can take it
        assign buf_r[b] = (state_q == MISS_IDLE) && gnt_any && (gnt_bank == BANK_ID_W'(b));
    end

    // Fixed priority where the lowest bank wins
    always_comb begin
        gnt_bank = '0;
        for (int b = N_BANKS - 1; b >= 0; b--) begin
            if (buf_rok[b]) begin
                gnt_bank = BANK_ID_W'(b);
            end
        end
    end

    assign gnt_any = |buf_rok;

    always_comb begin
        id_d.f.bank    = gnt_bank;
        id_d.f.mshr_id = buf_rdata[gnt_bank][MSHR_ID_W-1:0];
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= MISS_IDLE;
        end else if (state_q == MISS_IDLE) begin
            if (gnt_any) begin
                state_q <= MISS_SEND;
            end
        end else if (mem_req_ready_i) begin
            state_q <= MISS_IDLE;
        end
    end

    // Request payload is held stable while memory back-pressures
    always_ff @(posedge clk_i) begin
        if ((state_q == MISS_IDLE) && gnt_any) begin
            nline_q <= buf_rdata[gnt_bank][NLINE_W+MSHR_ID_W-1:MSHR_ID_W];
            id_q    <= id_d;
        end
    end

    assign mem_req_valid_o = (state_q == MISS_SEND);
    assign mem_req_addr_o  = {nline_q, {CL_OFFSET_W{1'b0}}};
    assign mem_req_id_o    = id_q.raw;

endmodule

`default_nettype wire

// File: design/refill_data_resize.sv
`timescale 1ns/1ps
`default_nettype none

module refill_data_resize
    import miss_handler_pkg::*;
(
    input  logic                     clk_i,
    input  logic                     rst_ni,
    input  logic                     w_i,
    input  logic [MEM_DATA_W-1:0]    wdata_i,
    input  logic                     wlast_i,
    output logic                     wok_o,
    input  logic                     r_i,
    output logic [REFILL_DATA_W-1:0] rdata_o
);

    logic [REFILL_DATA_W-1:0]                   slot_q [DATA_FIFO_DEPTH];
    // Depth is a power of two, so the pointers wrap on their own
    logic [$clog2(DATA_FIFO_DEPTH)-1:0]         wptr_q, rptr_q;
    logic [$clog2(DATA_FIFO_DEPTH+1)-1:0]       cnt_q;
    logic                                       whalf_q;
    logic                                       push_beat, chunk_done, pop;

    // The slot under construction is free as long as some slot is not full
    assign wok_o      = (cnt_q < DATA_FIFO_DEPTH);
    assign push_beat  = w_i && wok_o;
    assign chunk_done = push_beat && (whalf_q || wlast_i);
    assign pop        = r_i && (cnt_q != '0);
    assign rdata_o    = slot_q[rptr_q];

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            wptr_q  <= '0;
            rptr_q  <= '0;
            cnt_q   <= '0;
            whalf_q <= 1'b0;
        end else begin
            if (push_beat) begin
                whalf_q <= !chunk_done;
            end
            if (chunk_done) begin
                wptr_q <= wptr_q + 1'b1;
            end
            if (pop) begin
                rptr_q <= rptr_q + 1'b1;
            end
            case ({chunk_done, pop})
                2'b10:   cnt_q <= cnt_q + 1'b1;
                2'b01:   cnt_q <= cnt_q - 1'b1;
                default: cnt_q <= cnt_q;
            endcase
        end
    end

    // First beat of a chunk lands in the lower half
    always_ff @(posedge clk_i) begin
        if (push_beat) begin
            if (whalf_q) begin
                slot_q[wptr_q][REFILL_DATA_W-1:MEM_DATA_W] <= wdata_i;
            end else begin
                slot_q[wptr_q][MEM_DATA_W-1:0] <= wdata_i;
            end
        end
    end

endmodule

`default_nettype wire

// File: design/refill_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module refill_ctrl
    import miss_handler_pkg::*;
(
    input  logic                               clk_i,
    input  logic                               rst_ni,
    input  logic                               mem_resp_valid_i,
    input  logic                               mem_resp_last_i,
    input  logic                               mem_resp_error_i,
    input  logic [MEM_ID_W-1:0]                mem_resp_id_i,
    output logic                               mem_resp_ready_o,
    input  logic                               data_wok_i,
    input  logic [REFILL_DATA_W-1:0]           data_rdata_i,
    output logic                               data_w_o,
    output logic                               data_r_o,
    input  logic [N_BANKS-1:0]                 refill_req_ready_i,
    output logic [N_BANKS-1:0]                 refill_req_valid_o,
    output logic [N_BANKS-1:0]                 refill_write_data_o,
    output logic [N_BANKS-1:0]                 refill_write_dir_o,
    output logic [N_BANKS-1:0]                 refill_updt_rtab_o,
    output logic [REFILL_DATA_W-1:0]           refill_data_o,
    output logic [WORD_IDX_W-1:0]              refill_word_o,
    output logic                               refill_is_error_o,
    output logic                               refill_busy_o,
    output logic [N_BANKS-1:0]                 mshr_ack_o,
    output logic [N_BANKS-1:0]                 mshr_ack_cs_o,
    output logic [N_BANKS-1:0][MSHR_ID_W-1:0]  mshr_ack_id_o
);

    logic                  meta_w, meta_wok, meta_r, meta_rok;
    logic [MEM_ID_W:0]     meta_rdata;
    mem_id_u               meta_id;
    logic [BANK_ID_W-1:0]  bank;
    logic                  state_q, state_d;
    logic [WORD_IDX_W-1:0] cnt_q, cnt_d;

    // Every beat goes to the data FIFO, the metadata only with the last one
    assign data_w_o = mem_resp_valid_i && (meta_wok || !mem_resp_last_i);
    assign meta_w   = mem_resp_valid_i && mem_resp_last_i && data_wok_i;

    assign mem_resp_ready_o = mem_resp_valid_i && (meta_wok || !mem_resp_last_i) && data_wok_i;

    miss_fifo #(
        .WIDTH       (MEM_ID_W + 1),
        .DEPTH       (REFILL_FIFO_DEPTH),
        .FEEDTHROUGH (1'b0)
    ) i_meta_fifo (
        .clk_i   (clk_i),
        .rst_ni  (rst_ni),
        .w_i     (meta_w),
        .wdata_i ({mem_resp_error_i, mem_resp_id_i}),
        .wok_o   (meta_wok),
        .r_i     (meta_r),
        .rok_o   (meta_rok),
        .rdata_o (meta_rdata)
    );

    assign meta_id.raw = meta_rdata[MEM_ID_W-1:0];
    assign bank        = meta_id.f.bank;

    always_comb begin
        state_d             = state_q;
        cnt_d               = cnt_q;
        meta_r              = 1'b0;
        data_r_o            = 1'b0;
        refill_req_valid_o  = '0;
        refill_write_data_o = '0;
        refill_write_dir_o  = '0;
        refill_updt_rtab_o  = '0;
        mshr_ack_o          = '0;
        mshr_ack_cs_o       = '0;
        mshr_ack_id_o       = '0;

        if (state_q == REFILL_IDLE) begin
            if (meta_rok) begin
                refill_req_valid_o[bank] = 1'b1;
                // MSHR select goes up early, before the grant is known
                mshr_ack_cs_o[bank] = 1'b1;
                if (refill_req_ready_i[bank]) begin
                    mshr_ack_o[bank]    = 1'b1;
                    mshr_ack_id_o[bank] = meta_id.f.mshr_id;
                    cnt_d               = '0;
                    state_d             = REFILL_WRITE;
                end
            end
        end else begin
            // An error response still walks through the line, without data writes
            refill_write_data_o[bank] = !refill_is_error_o;
            data_r_o                  = 1'b1;
            cnt_d                     = cnt_q + WORD_IDX_W'(ACCESS_WORDS);
            if (cnt_q == WORD_IDX_W'(REFILL_LAST_WORD)) begin
                refill_write_dir_o[bank] = 1'b1;
                refill_updt_rtab_o[bank] = 1'b1;
                meta_r                   = 1'b1;
                state_d                  = REFILL_IDLE;
            end
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= REFILL_IDLE;
            cnt_q   <= '0;
        end else begin
            state_q <= state_d;
            cnt_q   <= cnt_d;
        end
    end

    assign refill_is_error_o = meta_rdata[MEM_ID_W];
    assign refill_busy_o     = (state_q == REFILL_WRITE);
    assign refill_word_o     = cnt_q;
    assign refill_data_o     = data_rdata_i;

endmodule

`default_nettype wire

// File: design/miss_handler.sv
`timescale 1ns/1ps
`default_nettype none

module miss_handler
    import miss_handler_pkg::*;
(
    input  logic                               clk_i,
    input  logic                               rst_ni,
    // Miss requests from the banks
    input  logic [N_BANKS-1:0]                 miss_req_valid_i,
    input  logic [N_BANKS-1:0][NLINE_W-1:0]    miss_req_nline_i,
    input  logic [N_BANKS-1:0][MSHR_ID_W-1:0]  miss_req_mshr_id_i,
    output logic [N_BANKS-1:0]                 miss_req_ready_o,
    // Memory read requests
    output logic                               mem_req_valid_o,
    output logic [ADDR_W-1:0]                  mem_req_addr_o,
    output logic [MEM_ID_W-1:0]                mem_req_id_o,
    input  logic                               mem_req_ready_i,
    // Memory responses
    input  logic                               mem_resp_valid_i,
    input  logic [MEM_DATA_W-1:0]              mem_resp_data_i,
    input  logic                               mem_resp_last_i,
    input  logic                               mem_resp_error_i,
    input  logic [MEM_ID_W-1:0]                mem_resp_id_i,
    output logic                               mem_resp_ready_o,
    // Refill towards the banks
    output logic [N_BANKS-1:0]                 refill_req_valid_o,
    input  logic [N_BANKS-1:0]                 refill_req_ready_i,
    output logic [N_BANKS-1:0]                 refill_write_data_o,
    output logic [N_BANKS-1:0]                 refill_write_dir_o,
    output logic [N_BANKS-1:0]                 refill_updt_rtab_o,
    output logic [REFILL_DATA_W-1:0]           refill_data_o,
    output logic [WORD_IDX_W-1:0]              refill_word_o,
    output logic                               refill_is_error_o,
    output logic                               refill_busy_o,
    // MSHR acknowledgment
    output logic [N_BANKS-1:0]                 mshr_ack_o,
    output logic [N_BANKS-1:0]                 mshr_ack_cs_o,
    output logic [N_BANKS-1:0][MSHR_ID_W-1:0]  mshr_ack_id_o
);

    logic                     data_w, data_wok, data_r;
    logic [REFILL_DATA_W-1:0] data_rdata;

    miss_req_path i_req_path (
        .clk_i              (clk_i),
        .rst_ni             (rst_ni),
        .miss_req_valid_i   (miss_req_valid_i),
        .miss_req_nline_i   (miss_req_nline_i),
        .miss_req_mshr_id_i (miss_req_mshr_id_i),
        .miss_req_ready_o   (miss_req_ready_o),
        .mem_req_ready_i    (mem_req_ready_i),
        .mem_req_valid_o    (mem_req_valid_o),
        .mem_req_addr_o     (mem_req_addr_o),
        .mem_req_id_o       (mem_req_id_o)
    );

    refill_data_resize i_data_fifo (
        .clk_i   (clk_i),
        .rst_ni  (rst_ni),
        .w_i     (data_w),
        .wdata_i (mem_resp_data_i),
        .wlast_i (mem_resp_last_i),
        .wok_o   (data_wok),
        .r_i     (data_r),
        .rdata_o (data_rdata)
    );

    refill_ctrl i_refill_ctrl (
        .clk_i               (clk_i),
        .rst_ni              (rst_ni),
        .mem_resp_valid_i    (mem_resp_valid_i),
        .mem_resp_last_i     (mem_resp_last_i),
        .mem_resp_error_i    (mem_resp_error_i),
        .mem_resp_id_i       (mem_resp_id_i),
        .mem_resp_ready_o    (mem_resp_ready_o),
        .data_wok_i          (data_wok),
        .data_rdata_i        (data_rdata),
        .data_w_o            (data_w),
        .data_r_o            (data_r),
        .refill_req_ready_i  (refill_req_ready_i),
        .refill_req_valid_o  (refill_req_valid_o),
        .refill_write_data_o (refill_write_data_o),
        .refill_write_dir_o  (refill_write_dir_o),
        .refill_updt_rtab_o  (refill_updt_rtab_o),
        .refill_data_o       (refill_data_o),
        .refill_word_o       (refill_word_o),
        .refill_is_error_o   (refill_is_error_o),
        .refill_busy_o       (refill_busy_o),
        .mshr_ack_o          (mshr_ack_o),
        .mshr_ack_cs_o       (mshr_ack_cs_o),
        .mshr_ack_id_o       (mshr_ack_id_o)
    );

endmodule

`default_nettype wire

// File: bench/tb_miss_handler.sv
`timescale 1ns/1ps
`default_nettype none

module tb_miss_handler
    import miss_handler_pkg::*;
();

    localparam int unsigned CLK_PERIOD      = 40;
    localparam int unsigned N_RANDOM        = 40;
    localparam int unsigned N_TOTAL         = N_RANDOM + 2;
    localparam int unsigned WATCHDOG_CYCLES = N_TOTAL * 60;
    localparam int unsigned BEATS           = 4;
    localparam int unsigned CHK_W           = REFILL_DATA_W;
    localparam int unsigned REQ_W           = NLINE_W + MSHR_ID_W;

    logic                               clk_i = 1'b0;
    logic                               rst_ni = 1'b0;
    logic [N_BANKS-1:0]                 miss_req_valid_i = '0;
    logic [N_BANKS-1:0][NLINE_W-1:0]    miss_req_nline_i = '0;
    logic [N_BANKS-1:0][MSHR_ID_W-1:0]  miss_req_mshr_id_i = '0;
    logic                               mem_req_ready_i = 1'b0;
    logic                               mem_resp_valid_i = 1'b0;
    logic [MEM_DATA_W-1:0]              mem_resp_data_i = '0;
    logic                               mem_resp_last_i = 1'b0;
    logic                               mem_resp_error_i = 1'b0;
    logic [MEM_ID_W-1:0]                mem_resp_id_i = '0;
    logic [N_BANKS-1:0]                 refill_req_ready_i = '0;
    logic [N_BANKS-1:0]                 miss_req_ready_o, refill_req_valid_o, mshr_ack_o;
    logic [N_BANKS-1:0]                 refill_write_data_o, refill_write_dir_o;
    logic [N_BANKS-1:0]                 refill_updt_rtab_o, mshr_ack_cs_o;
    logic [N_BANKS-1:0][MSHR_ID_W-1:0]  mshr_ack_id_o;
    logic                               mem_req_valid_o, mem_resp_ready_o;
    logic                               refill_is_error_o, refill_busy_o;
    logic [ADDR_W-1:0]                  mem_req_addr_o;
    logic [MEM_ID_W-1:0]                mem_req_id_o;
    logic [REFILL_DATA_W-1:0]           refill_data_o;
    logic [WORD_IDX_W-1:0]              refill_word_o;

    // Scoreboard state
    int unsigned         checks = 0, errors = 0, errors_base = 0, n_tests = 0;
    string               cur_test = "none";
    int unsigned         beats_taken = 0, beat_base = 0, pend_rd = 0;
    int unsigned         refills_done = 0, refill_phase = 0;
    logic [REQ_W-1:0]    fwd_q [N_BANKS][$];
    logic [MEM_ID_W-1:0] pend_q [$], sent_ids [$], exp_id_q [$];
    logic                exp_err_q [$];
    logic [MEM_ID_W-1:0] cur_id;
    logic                cur_err;
    logic [N_BANKS-1:0]  bank_mask;

    miss_handler DUT (.*);

    initial begin
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    task automatic report_problem(input string msg);
        errors++;
        $display("ERROR in %s: %s", cur_test, msg);
    endtask

    task automatic check_eq(input string name, input logic [CHK_W-1:0] exp,
                            input logic [CHK_W-1:0] act);
        checks++;
        assert (exp === act) else begin
            errors++;
            $display("FAILED %s/%s: expected %0h, actual %0h", cur_test, name, exp, act);
        end
    endtask

    task automatic test_start(input string name);
        cur_test    = name;
        errors_base = errors;
    endtask

    task automatic test_end();
        n_tests++;
        $display("Test %s finished with %0d errors", cur_test, errors - errors_base);
    endtask

    // Beat contents follow the transaction ID and the beat number
    function automatic logic [MEM_DATA_W-1:0] beat_data(input logic [MEM_ID_W-1:0] id,
                                                        input int beat);
        return {8'hd5, 20'h0, id, 30'h0, 2'(beat)} ^ 64'h0123_4567_89ab_cdef;
    endfunction

    // Each chunk holds two beats with the earlier one in the lower half
    function automatic logic [REFILL_DATA_W-1:0] chunk_data(input logic [MEM_ID_W-1:0] id,
                                                            input int half);
        return {beat_data(id, 2 * half + 1), beat_data(id, 2 * half)};
    endfunction

    task automatic check_reset_outputs();
        check_eq("reset_outputs", '0, CHK_W'({mem_req_valid_o, refill_req_valid_o,
            refill_write_data_o, refill_write_dir_o, refill_updt_rtab_o, mshr_ack_o,
            mshr_ack_cs_o, refill_busy_o}));
    endtask

    task automatic issue_misses(input int b, input int n);
        @(negedge clk_i);
        for (int i = 0; i < n; i++) begin
            while ($urandom_range(3) == 0) @(negedge clk_i);
            miss_req_valid_i[b]   = 1'b1;
            miss_req_nline_i[b]   = NLINE_W'($urandom);
            miss_req_mshr_id_i[b] = MSHR_ID_W'(i);
            do @(posedge clk_i); while (!miss_req_ready_o[b]);
            @(negedge clk_i);
            miss_req_valid_i[b] = 1'b0;
        end
    endtask

    // Memory and bank models drive all their inputs on the falling edge
    always @(negedge clk_i) begin
        if (rst_ni) begin
            mem_req_ready_i    = 1'($urandom);
            refill_req_ready_i = N_BANKS'($urandom);
            if (mem_resp_valid_i && (beats_taken - beat_base == BEATS)) begin
                mem_resp_valid_i = 1'b0;
            end
            if (!mem_resp_valid_i && (pend_rd < pend_q.size()) && ($urandom_range(2) != 0)) begin
                mem_resp_id_i    = pend_q[pend_rd];
                mem_resp_error_i = ($urandom_range(3) == 0);
                pend_rd++;
                beat_base        = beats_taken;
                mem_resp_valid_i = 1'b1;
            end
            mem_resp_last_i = mem_resp_valid_i && (beats_taken - beat_base == BEATS - 1);
            mem_resp_data_i = beat_data(mem_resp_id_i, int'(beats_taken - beat_base));
        end
    end

    always @(posedge clk_i) begin : monitor
        int unsigned req_bank;
        logic [REQ_W-1:0] exp_miss;
        if (rst_ni) begin
            for (int b = 0; b < N_BANKS; b++) begin
                if (miss_req_valid_i[b] && miss_req_ready_o[b]) begin
                    fwd_q[b].push_back({miss_req_nline_i[b], miss_req_mshr_id_i[b]});
                end
            end
            if (mem_req_valid_o && mem_req_ready_i) begin
                req_bank = int'(mem_req_id_o[MEM_ID_W-1]);
                if (fwd_q[req_bank].size() == 0) begin
                    report_problem("memory request without a pending miss");
                end else begin
                    exp_miss = fwd_q[req_bank].pop_front();
                    check_eq("req_addr", CHK_W'({exp_miss[REQ_W-1:MSHR_ID_W], 5'b0}),
                             CHK_W'(mem_req_addr_o));
                    check_eq("req_mshr_id", CHK_W'(exp_miss[MSHR_ID_W-1:0]),
                             CHK_W'(mem_req_id_o[MSHR_ID_W-1:0]));
                end
                pend_q.push_back(mem_req_id_o);
                sent_ids.push_back(mem_req_id_o);
            end
            if (mem_resp_valid_i && mem_resp_ready_o) begin
                beats_taken++;
                if (mem_resp_last_i) begin
                    exp_id_q.push_back(mem_resp_id_i);
                    exp_err_q.push_back(mem_resp_error_i);
                end
            end
            check_eq("mshr_ack_cs", CHK_W'(refill_req_valid_o), CHK_W'(mshr_ack_cs_o));
            if (refill_phase == 0) begin
                check_eq("idle_writes", '0, CHK_W'({refill_write_data_o, refill_write_dir_o,
                                                    refill_updt_rtab_o, refill_busy_o}));
                if ((refill_req_valid_o & refill_req_ready_i) != '0) begin
                    if (exp_id_q.size() == 0) begin
                        report_problem("refill granted with no completed response");
                    end else begin
                        cur_id    = exp_id_q[0];
                        cur_err   = exp_err_q[0];
                        bank_mask = '0;
                        bank_mask[cur_id[MEM_ID_W-1]] = 1'b1;
                        check_eq("refill_req_bank", CHK_W'(bank_mask), CHK_W'(refill_req_valid_o));
                        check_eq("mshr_ack", CHK_W'(bank_mask), CHK_W'(mshr_ack_o));
                        check_eq("mshr_ack_id", CHK_W'(cur_id[MSHR_ID_W-1:0]),
                                 CHK_W'(mshr_ack_id_o[cur_id[MEM_ID_W-1]]));
                        refill_phase = 1;
                    end
                end else begin
                    check_eq("mshr_ack_idle", '0, CHK_W'(mshr_ack_o));
                end
            end else begin
                check_eq("refill_word", CHK_W'(2 * (refill_phase - 1)), CHK_W'(refill_word_o));
                check_eq("refill_data", chunk_data(cur_id, int'(refill_phase - 1)), refill_data_o);
                check_eq("write_data", cur_err ? '0 : CHK_W'(bank_mask),
                         CHK_W'(refill_write_data_o));
                check_eq("is_error", CHK_W'(cur_err), CHK_W'(refill_is_error_o));
                check_eq("busy", CHK_W'(1), CHK_W'(refill_busy_o));
                check_eq("ack_in_write", '0, CHK_W'({mshr_ack_o, refill_req_valid_o}));
                // Directory and retry table only on the last chunk
                check_eq("write_dir", (refill_phase == 2) ? CHK_W'(bank_mask) : '0,
                         CHK_W'(refill_write_dir_o));
                check_eq("updt_rtab", (refill_phase == 2) ? CHK_W'(bank_mask) : '0,
                         CHK_W'(refill_updt_rtab_o));
                if (refill_phase == 2) begin
                    void'(exp_id_q.pop_front());
                    void'(exp_err_q.pop_front());
                    refills_done++;
                    refill_phase = 0;
                end else begin
                    refill_phase = 2;
                end
            end
        end
    end

    assert property (@(posedge clk_i) disable iff (!rst_ni)
        (mem_req_valid_o && !mem_req_ready_i) |=>
        (mem_req_valid_o && $stable(mem_req_addr_o) && $stable(mem_req_id_o)))
        else report_problem("memory request changed while stalled");

    assert property (@(posedge clk_i) disable iff (!rst_ni)
        (mem_resp_valid_i && mem_resp_ready_o && mem_resp_last_i && !refill_busy_o &&
         (refill_req_valid_o == '0)) |=> (refill_req_valid_o != '0))
        else report_problem("refill request did not follow the last beat");

    for (genvar b = 0; b < N_BANKS; b++) begin : gen_hold_chk
        assert property (@(posedge clk_i) disable iff (!rst_ni)
            (refill_req_valid_o[b] && !refill_req_ready_i[b]) |=>
            (refill_req_valid_o[b] && mshr_ack_cs_o[b]))
            else report_problem("refill request dropped before its grant");
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk_i);
        $display("Watchdog expired after %0d cycles, traffic did not drain", WATCHDOG_CYCLES);
        $display("Simulation FAILED");
        $finish;
    end

    initial begin
        void'($urandom(32'h8062_b02c));
        test_start("reset");
        repeat (4) @(negedge clk_i);
        check_reset_outputs();
        rst_ni = 1'b1;
        @(negedge clk_i);
        check_reset_outputs();
        test_end();

        // Both banks miss in the same cycle into empty buffers
        test_start("priority");
        miss_req_valid_i      = 2'b11;
        miss_req_nline_i[0]   = 27'h0abcdef;
        miss_req_nline_i[1]   = 27'h5a5a5a5;
        miss_req_mshr_id_i[0] = 3'd5;
        miss_req_mshr_id_i[1] = 3'd6;
        @(posedge clk_i);
        check_eq("prio_accept", CHK_W'(2'b11), CHK_W'(miss_req_ready_o));
        @(negedge clk_i);
        miss_req_valid_i = '0;
        check_eq("prio_first_valid", CHK_W'(1), CHK_W'(mem_req_valid_o));
        check_eq("prio_first_id", CHK_W'(4'b0101), CHK_W'(mem_req_id_o));
        wait (refills_done == 2);
        check_eq("prio_order", CHK_W'(8'b0101_1110), CHK_W'({sent_ids[0], sent_ids[1]}));
        test_end();

        test_start("random_traffic");
        fork
            issue_misses(0, N_RANDOM / 2);
            issue_misses(1, N_RANDOM / 2);
        join
        wait (refills_done == N_TOTAL);
        check_eq("requests_sent", CHK_W'(N_TOTAL), CHK_W'(sent_ids.size()));
        check_eq("misses_left", '0, CHK_W'(fwd_q[0].size() + fwd_q[1].size()));
        check_eq("refills_left", '0, CHK_W'(exp_id_q.size()));
        test_end();

        $display("Tests run %0d, checks %0d, errors %0d", n_tests, checks, errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: vlog.f
design/miss_handler_pkg.sv
design/miss_fifo.sv
design/miss_req_path.sv
design/refill_data_resize.sv
design/refill_ctrl.sv
design/miss_handler.sv
bench/tb_miss_handler.sv

// File: run.sh
#!/bin/sh
# Compile and run the miss handler testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module tb_miss_handler \
    -f vlog.f -Mdir obj_dir -o tb_miss_handler
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_miss_handler > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulator exited with status $status"
    exit 1
fi

if grep -q "Simulation PASSED" "$LOG"; then
    exit 0
fi
exit 1
